/* rtl/xgmii_rx_pkg.sv */
//////////////////////////////
// XGMII and Ethernet constants, lane counts
// and the receive state type
//////////////////////////////

package xgmii_rx_pkg;

    // XGMII control characters, valid only on lanes whose control flag is set
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_END   = 8'hfd;

    // seven preamble bytes followed by the SFD, lane 0 in the low byte
    // the start character replaces lane 0 on the wire, so only the upper
    // seven bytes are ever compared
    localparam logic [63:0] ETH_PREAMBLE = 64'hd555_5555_5555_5555;

    // one bus word carries eight byte lanes
    localparam int LANES = 8;

    // a shifted frame is built from two half-words of four lanes each
    localparam int HALF_LANES = 4;

    // receive states of the framer
    // shifted preamble lasts exactly one word, while the second half of
    // the preamble is still on the lower lanes of the bus
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_SHIFTED_PREAMBLE,
        RX_UNSHIFTED,
        RX_SHIFTED
    } rx_state_t;

endpackage

/* rtl/xgmii_word_if.sv */
//////////////////////////////
// registered XGMII word with its end-of-frame masks
//////////////////////////////

interface xgmii_word_if;

    // bus word one cycle after the pins
    logic [xgmii_rx_pkg::LANES*8-1:0] data;
    logic [xgmii_rx_pkg::LANES-1:0]   ctrl;

    // one bit per lane in front of the first end character of that word
    logic [xgmii_rx_pkg::LANES-1:0] keep;

    // upper half of the word received before data, needed to rebuild beats
    // of a frame that started on lane 4
    logic [xgmii_rx_pkg::HALF_LANES*8-1:0] prev_data;
    logic [xgmii_rx_pkg::HALF_LANES-1:0]   prev_ctrl;
    logic [xgmii_rx_pkg::HALF_LANES-1:0]   prev_keep;

    // the word still at the pins opens with an end character
    logic next_end;

    modport decode (
        output data,
        output ctrl,
        output keep,
        output prev_data,
        output prev_ctrl,
        output prev_keep,
        output next_end
    );

    modport framer (
        input data,
        input ctrl,
        input keep,
        input prev_data,
        input prev_ctrl,
        input prev_keep,
        input next_end
    );

endinterface

/* rtl/xgmii_rx_decode.sv */
//////////////////////////////
// XGMII input register, end-of-frame keep mask
// and lookahead on the next word
//////////////////////////////

module xgmii_rx_decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [xgmii_rx_pkg::LANES*8-1:0] xgmii_data,
    input  logic [xgmii_rx_pkg::LANES-1:0]   xgmii_ctrl,
    xgmii_word_if.decode                     word
);

    localparam int LANES = xgmii_rx_pkg::LANES;
    localparam int HALF_LANES = xgmii_rx_pkg::HALF_LANES;

    // keep mask of the word at the pins, registered together with it
    logic [LANES-1:0] keep_scan;

    // registered word, feeding both the interface and the half-word store
    logic [LANES*8-1:0] data_q;
    logic [LANES-1:0]   ctrl_q;
    logic [LANES-1:0]   keep_q;

    // the mask stays open from lane 0 upward until the first end character
    // and every lane from there on is cleared
    // the scan runs on the unregistered word so that the register after it
    // cuts the chain of lanes away from the framer logic
    always_comb begin : end_scan
        logic open;
        open = 1'b1;
        for (int i = 0; i < LANES; i++) begin
            if (xgmii_ctrl[i] && (xgmii_data[i*8 +: 8] == xgmii_rx_pkg::XGMII_END)) begin
                open = 1'b0;
            end
            keep_scan[i] = open;
        end
    end

    // plain pipeline register, the word only carries payload and flags
    always_ff @(posedge clk) begin
        data_q <= xgmii_data;
        ctrl_q <= xgmii_ctrl;
        keep_q <= keep_scan;
    end

    // upper half of the word before data_q
    // after reset it looks like an idle half-word with no frame in it, so a
    // shifted start seen right out of reset compares against idle characters
    always_ff @(posedge clk) begin
        if (rst) begin
            word.prev_data <= {HALF_LANES{xgmii_rx_pkg::XGMII_IDLE}};
            word.prev_ctrl <= '1;
            word.prev_keep <= '0;
        end else begin
            word.prev_data <= data_q[LANES*8-1:HALF_LANES*8];
            word.prev_ctrl <= ctrl_q[LANES-1:HALF_LANES];
            word.prev_keep <= keep_q[LANES-1:HALF_LANES];
        end
    end

    assign word.data = data_q;
    assign word.ctrl = ctrl_q;
    assign word.keep = keep_q;

    // lookahead: an end character on lane 0 of the next word means the
    // current full word is already the last beat of the frame
    // without this the framer would have to send a beat with no bytes kept
    assign word.next_end = xgmii_ctrl[0]
        && (xgmii_data[7:0] == xgmii_rx_pkg::XGMII_END);

endmodule

/* rtl/xgmii_rx_framer.sv */
//////////////////////////////
// receive FSM, preamble check, shifted alignment
// and AXI4-Stream beat output
//////////////////////////////

module xgmii_rx_framer (
    input  logic                             clk,
    input  logic                             rst,
    xgmii_word_if.framer                     word,
    input  logic                             axis_tready,
    output logic                             axis_tvalid,
    output logic [xgmii_rx_pkg::LANES*8-1:0] axis_tdata,
    output logic [xgmii_rx_pkg::LANES-1:0]   axis_tkeep,
    output logic                             axis_tlast,
    output logic                             error_ready,
    output logic                             error_preamble,
    output logic                             error_xgmii
);

    localparam int LANES = xgmii_rx_pkg::LANES;
    localparam int HALF_LANES = xgmii_rx_pkg::HALF_LANES;

    xgmii_rx_pkg::rx_state_t state, state_next;

    // set for one word after a frame that was closed by the lookahead, the
    // end character then still sits on lane 0 of the word seen in idle
    logic tolerate_end, tolerate_end_next;

    // next values of the registered outputs
    logic               beat_valid;
    logic               beat_last;
    logic [LANES-1:0]   beat_keep;
    logic [LANES*8-1:0] beat_data;
    logic               err_ready_next;
    logic               err_preamble_next;
    logic               err_xgmii_next;

    // decoded lane conditions of the current word
    logic start_lane0;
    logic start_lane4;
    logic end_lane4;
    logic preamble_ok;
    logic shifted_preamble_ok;
    logic lower_idle;
    logic upper_idle;

    assign start_lane0 = word.ctrl[0] && (word.data[7:0] == xgmii_rx_pkg::XGMII_START);
    assign start_lane4 = word.ctrl[HALF_LANES]
        && (word.data[HALF_LANES*8 +: 8] == xgmii_rx_pkg::XGMII_START);
    assign end_lane4 = word.ctrl[HALF_LANES]
        && (word.data[HALF_LANES*8 +: 8] == xgmii_rx_pkg::XGMII_END);

    // whole preamble and SFD in lanes 1 to 7, all of them data lanes
    assign preamble_ok = (word.ctrl[LANES-1:1] == '0)
        && (word.data[LANES*8-1:8] == xgmii_rx_pkg::ETH_PREAMBLE[63:8]);

    // preamble split across words, three bytes in the previous upper half
    // behind the start character and four in the current lower half
    assign shifted_preamble_ok = ({word.ctrl[HALF_LANES-1:0], word.prev_ctrl[HALF_LANES-1:1]} == '0)
        && ({word.data[HALF_LANES*8-1:0], word.prev_data[HALF_LANES*8-1:8]}
            == xgmii_rx_pkg::ETH_PREAMBLE[63:8]);

    assign lower_idle = (word.ctrl[HALF_LANES-1:0] == '1)
        && (word.data[HALF_LANES*8-1:0] == {HALF_LANES{xgmii_rx_pkg::XGMII_IDLE}});

    // lanes 1 to 7 idle, lane 0 is judged on its own in the idle state
    assign upper_idle = (word.ctrl == '1)
        && (word.data[LANES*8-1:8] == {(LANES-1){xgmii_rx_pkg::XGMII_IDLE}});

    always_comb begin
        state_next = state;
        tolerate_end_next = 1'b0;
        beat_valid = 1'b0;
        beat_last = 1'b0;
        beat_keep = '1;
        beat_data = word.data;
        err_ready_next = 1'b0;
        err_preamble_next = 1'b0;
        err_xgmii_next = 1'b0;

        case (state)
            xgmii_rx_pkg::RX_IDLE: begin
                if (start_lane0) begin
                    // a broken preamble leaves the FSM in idle, the frame body
                    // then shows up as bus errors which are expected here
                    if (preamble_ok) begin
                        state_next = xgmii_rx_pkg::RX_UNSHIFTED;
                    end else begin
                        err_preamble_next = 1'b1;
                    end
                end else if (start_lane4) begin
                    // the gap before a frame is long enough that the lower
                    // half must hold nothing but idle characters
                    if (!lower_idle) begin
                        err_xgmii_next = 1'b1;
                    end
                    state_next = xgmii_rx_pkg::RX_SHIFTED_PREAMBLE;
                end else if (!upper_idle) begin
                    err_xgmii_next = 1'b1;
                end else if (tolerate_end) begin
                    if (word.data[7:0] != xgmii_rx_pkg::XGMII_END) begin
                        err_xgmii_next = 1'b1;
                    end
                end else if (word.data[7:0] != xgmii_rx_pkg::XGMII_IDLE) begin
                    err_xgmii_next = 1'b1;
                end
            end

            xgmii_rx_pkg::RX_SHIFTED_PREAMBLE: begin
                // the upper half of this word is the first payload half-word,
                // an end on lane 4 means a frame without any bytes
                if (!shifted_preamble_ok || end_lane4) begin
                    err_preamble_next = 1'b1;
                    state_next = xgmii_rx_pkg::RX_IDLE;
                end else begin
                    state_next = xgmii_rx_pkg::RX_SHIFTED;
                end
            end

            xgmii_rx_pkg::RX_UNSHIFTED: begin
                if (word.keep == '0) begin
                    // end directly after the preamble, there is nothing to send
                    err_preamble_next = 1'b1;
                    state_next = xgmii_rx_pkg::RX_IDLE;
                end else begin
                    beat_valid = 1'b1;
                    err_ready_next = !axis_tready;
                    if (word.keep != '1) begin
                        beat_last = 1'b1;
                        beat_keep = word.keep;
                        state_next = xgmii_rx_pkg::RX_IDLE;
                    end else if (word.next_end) begin
                        beat_last = 1'b1;
                        tolerate_end_next = 1'b1;
                        state_next = xgmii_rx_pkg::RX_IDLE;
                    end
                    // a control flag on a kept lane is a corrupted frame body
                    if ((word.ctrl & word.keep) != '0) begin
                        err_xgmii_next = 1'b1;
                        beat_last = 1'b1;
                        state_next = xgmii_rx_pkg::RX_IDLE;
                    end
                end
            end

            xgmii_rx_pkg::RX_SHIFTED: begin
                beat_valid = 1'b1;
                beat_data = {word.data[HALF_LANES*8-1:0], word.prev_data};
                err_ready_next = !axis_tready;
                // the two masks come from different bus words, so the lower
                // mask can be full again after the previous half has ended
                // and the previous half is therefore tested first
                if (word.prev_keep != '1) begin
                    beat_last = 1'b1;
                    beat_keep = {{HALF_LANES{1'b0}}, word.prev_keep};
                    state_next = xgmii_rx_pkg::RX_IDLE;
                end else if (word.keep[HALF_LANES-1:0] != '1) begin
                    beat_last = 1'b1;
                    beat_keep = {word.keep[HALF_LANES-1:0], {HALF_LANES{1'b1}}};
                    state_next = xgmii_rx_pkg::RX_IDLE;
                end else if (end_lane4) begin
                    // the following shifted beat would open with the end
                    // character, so this full beat closes the frame
                    beat_last = 1'b1;
                    state_next = xgmii_rx_pkg::RX_IDLE;
                end
                if (((word.prev_ctrl & word.prev_keep) != '0)
                        || ((word.prev_keep == '1)
                            && ((word.ctrl[HALF_LANES-1:0] & word.keep[HALF_LANES-1:0]) != '0))) begin
                    err_xgmii_next = 1'b1;
                    beat_last = 1'b1;
                    state_next = xgmii_rx_pkg::RX_IDLE;
                end
            end

            default: begin
                state_next = xgmii_rx_pkg::RX_IDLE;
            end
        endcase
    end

    // control state and single-cycle pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= xgmii_rx_pkg::RX_IDLE;
            tolerate_end <= 1'b0;
            axis_tvalid <= 1'b0;
            axis_tlast <= 1'b0;
            error_ready <= 1'b0;
            error_preamble <= 1'b0;
            error_xgmii <= 1'b0;
        end else begin
            state <= state_next;
            tolerate_end <= tolerate_end_next;
            axis_tvalid <= beat_valid;
            axis_tlast <= beat_last;
            error_ready <= err_ready_next;
            error_preamble <= err_preamble_next;
            error_xgmii <= err_xgmii_next;
        end
    end

    // beat payload, only meaningful while axis_tvalid is high
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            axis_tdata <= beat_data;
            axis_tkeep <= beat_keep;
        end
    end

endmodule

/* rtl/xgmii_axis_rx.sv */
//////////////////////////////
// XGMII to AXI4-Stream receive top level
//////////////////////////////

module xgmii_axis_rx (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [xgmii_rx_pkg::LANES*8-1:0] xgmii_data,
    input  logic [xgmii_rx_pkg::LANES-1:0]   xgmii_ctrl,
    input  logic                             axis_tready,
    output logic                             axis_tvalid,
    output logic [xgmii_rx_pkg::LANES*8-1:0] axis_tdata,
    output logic [xgmii_rx_pkg::LANES-1:0]   axis_tkeep,
    output logic                             axis_tlast,
    output logic                             error_ready,
    output logic                             error_preamble,
    output logic                             error_xgmii
);

    // registered word and masks between the two stages
    xgmii_word_if word_bus ();

    // stage one registers the bus word and works out where a frame ends
    xgmii_rx_decode i_decode (
        .clk        (clk),
        .rst        (rst),
        .xgmii_data (xgmii_data),
        .xgmii_ctrl (xgmii_ctrl),
        .word       (word_bus.decode)
    );

    // stage two runs the FSM and drives every output from a register
    xgmii_rx_framer i_framer (
        .clk            (clk),
        .rst            (rst),
        .word           (word_bus.framer),
        .axis_tready    (axis_tready),
        .axis_tvalid    (axis_tvalid),
        .axis_tdata     (axis_tdata),
        .axis_tkeep     (axis_tkeep),
        .axis_tlast     (axis_tlast),
        .error_ready    (error_ready),
        .error_preamble (error_preamble),
        .error_xgmii    (error_xgmii)
    );

endmodule

/* dv/tb_clock_gen.sv */
//////////////////////////////
// testbench clock and reset
//////////////////////////////

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // period of 10 time units
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset is held over the first three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* dv/xgmii_axis_rx_tb.sv */
//////////////////////////////
// testbench with frame generator,
// beat and error model, checks and timeout
//////////////////////////////

module xgmii_axis_rx_tb;

    localparam logic [7:0]  IDLE = xgmii_rx_pkg::XGMII_IDLE;
    localparam logic [63:0] PREAMBLE = xgmii_rx_pkg::ETH_PREAMBLE;
    localparam int GOOD = 0;
    localparam int BAD_PREAMBLE = 1;
    localparam int CTRL_ERROR = 2;
    localparam int FRAMES = 80;

    logic        clk;
    logic        rst;
    logic [63:0] xgmii_data;
    logic [7:0]  xgmii_ctrl;
    logic        axis_tready;
    logic        axis_tvalid;
    logic [63:0] axis_tdata;
    logic [7:0]  axis_tkeep;
    logic        axis_tlast;
    logic        error_ready;
    logic        error_preamble;
    logic        error_xgmii;

    // byte stream for the pins, lane 0 first, with flags per byte
    // allow marks bytes of broken frames whose words may raise error_xgmii
    // pre marks the byte whose word must raise error_preamble
    logic [7:0] lane_data[$];
    logic       lane_ctrl[$];
    logic       lane_allow[$];
    logic       lane_pre[$];

    // expected beats packed as {error_xgmii, last, keep, data}
    logic [73:0] beat_q[$];

    // index of the pin word whose outputs carry each expected beat
    int beat_word[$];

    logic frame_dirty;
    int   nwords;
    int   limit;
    int   cycles;

    tb_clock_gen i_clock_gen (.clk(clk), .rst(rst));

    xgmii_axis_rx i_xgmii_axis_rx (
        .clk            (clk),
        .rst            (rst),
        .xgmii_data     (xgmii_data),
        .xgmii_ctrl     (xgmii_ctrl),
        .axis_tready    (axis_tready),
        .axis_tvalid    (axis_tvalid),
        .axis_tdata     (axis_tdata),
        .axis_tkeep     (axis_tkeep),
        .axis_tlast     (axis_tlast),
        .error_ready    (error_ready),
        .error_preamble (error_preamble),
        .error_xgmii    (error_xgmii)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        stop_with_failure($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    function automatic logic [63:0] keep_to_mask(input logic [7:0] keep);
        logic [63:0] mask;
        for (int i = 0; i < 8; i++) begin
            mask[i*8 +: 8] = {8{keep[i]}};
        end
        return mask;
    endfunction

    task automatic put_byte(input logic [7:0] d, input logic c, input logic pre);
        lane_data.push_back(d);
        lane_ctrl.push_back(c);
        lane_allow.push_back(frame_dirty);
        lane_pre.push_back(pre);
    endtask

    // one frame with its gap in front, then the beats the sink should see
    task automatic add_frame(input int len, input bit shifted, input int kind);
        logic [7:0]  payload[$];
        logic [7:0]  d;
        logic [73:0] beat;
        int          bad_pos;
        int          err_pos;
        int          last_beat;
        int          start_word;
        repeat (shifted ? 20 : 16) put_byte(IDLE, 1'b1, 1'b0);
        bad_pos = (kind == BAD_PREAMBLE) ? int'($urandom % 7) : -1;
        err_pos = (kind == CTRL_ERROR) ? int'($urandom % len) : -1;
        frame_dirty = (kind != GOOD);
        start_word = lane_data.size() / 8;
        put_byte(xgmii_rx_pkg::XGMII_START, 1'b1, 1'b0);
        // the SFD word is the one that decides on the preamble
        for (int i = 0; i < 7; i++) begin
            d = PREAMBLE[(i+1)*8 +: 8];
            if (i == bad_pos) begin
                d = d ^ 8'(1 + $urandom % 255);
            end
            put_byte(d, 1'b0, (i == 6) && (kind == BAD_PREAMBLE));
        end
        // a flagged error character stands in for one payload byte
        for (int i = 0; i < len; i++) begin
            d = (i == err_pos) ? 8'hfe : 8'($urandom);
            payload.push_back(d);
            put_byte(d, i == err_pos, 1'b0);
        end
        put_byte(xgmii_rx_pkg::XGMII_END, 1'b1, 1'b0);
        while (lane_data.size() % 8 != 0) begin
            put_byte(IDLE, 1'b1, 1'b0);
        end
        frame_dirty = 1'b0;
        if (kind == BAD_PREAMBLE) begin
            return;
        end
        // eight bytes per beat, the beat holding the error closes the frame
        last_beat = (kind == CTRL_ERROR) ? err_pos / 8 : (len - 1) / 8;
        for (int b = 0; b <= last_beat; b++) begin
            beat = '0;
            for (int i = 0; i < 8; i++) begin
                if (b * 8 + i < len) begin
                    beat[i*8 +: 8] = payload[b*8+i];
                    beat[64+i] = 1'b1;
                end
            end
            beat[72] = (b == last_beat);
            beat[73] = (kind == CTRL_ERROR) && (b == last_beat);
            beat_q.push_back(beat);
            // a shifted beat also needs the lower half of the following word
            beat_word.push_back(start_word + (shifted ? 2 : 1) + b);
        end
    endtask

    // outputs caused by the word that was at the pins two cycles ago
    task automatic check_outputs(input int w);
        logic        pre_exp;
        logic        allow;
        logic        valid_exp;
        logic [73:0] beat;
        pre_exp = 1'b0;
        allow = 1'b0;
        if (w >= 0 && w < nwords) begin
            for (int i = 0; i < 8; i++) begin
                pre_exp = pre_exp | lane_pre[w*8+i];
                allow = allow | lane_allow[w*8+i];
            end
        end
        valid_exp = (beat_word.size() > 0) && (beat_word[0] == w);
        assert (axis_tvalid == valid_exp)
            else value_error($sformatf("tvalid %b, expected %b", axis_tvalid, valid_exp));
        assert (error_ready == (axis_tvalid && !axis_tready))
            else value_error($sformatf("error_ready is %b", error_ready));
        assert (error_preamble == pre_exp)
            else value_error($sformatf("error_preamble is %b, expected %b", error_preamble, pre_exp));
        if (axis_tvalid) begin
            assert (beat_q.size() > 0) else value_error("beat issued with none expected");
            beat = beat_q.pop_front();
            void'(beat_word.pop_front());
            assert (axis_tkeep == beat[71:64])
                else value_error($sformatf("tkeep %h, expected %h", axis_tkeep, beat[71:64]));
            assert ((axis_tdata & keep_to_mask(beat[71:64])) == beat[63:0])
                else value_error($sformatf("tdata %h, expected %h", axis_tdata, beat[63:0]));
            assert (axis_tlast == beat[72])
                else value_error($sformatf("tlast %b, expected %b", axis_tlast, beat[72]));
            assert (error_xgmii == beat[73])
                else value_error($sformatf("error_xgmii %b on a beat", error_xgmii));
        end else begin
            assert (!error_xgmii || allow) else value_error("error_xgmii outside a broken frame");
        end
    endtask

    task automatic drive_word(input int w);
        for (int i = 0; i < 8; i++) begin
            if (w < nwords) begin
                xgmii_data[i*8 +: 8] = lane_data[w*8+i];
                xgmii_ctrl[i] = lane_ctrl[w*8+i];
            end else begin
                xgmii_data[i*8 +: 8] = IDLE;
                xgmii_ctrl[i] = 1'b1;
            end
        end
        axis_tready = ($urandom % 4) != 0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles, stream never finished", cycles));
        end
    end

    initial begin
        int kind;
        int len;
        bit shifted;
        xgmii_data = {8{IDLE}};
        xgmii_ctrl = '1;
        axis_tready = 1'b1;
        frame_dirty = 1'b0;
        void'($urandom(40));
        // first six frames are 8, 16 and 32 bytes on both start lanes
        for (int f = 0; f < FRAMES; f++) begin
            len = (f < 6) ? (8 << (f % 3)) : 1 + int'($urandom % 40);
            shifted = (f < 6) ? (f >= 3) : ($urandom % 2 == 1);
            kind = int'($urandom % 8);
            if (f < 6 || kind > CTRL_ERROR) begin
                kind = GOOD;
            end
            add_frame(len, shifted, kind);
        end
        repeat (32) put_byte(IDLE, 1'b1, 1'b0);
        nwords = lane_data.size() / 8;
        limit = nwords + 50;
        wait (rst == 1'b0);
        for (int w = 0; w < nwords + 2; w++) begin
            @(negedge clk);
            check_outputs(w - 2);
            drive_word(w);
        end
        if (beat_q.size() != 0) begin
            stop_with_failure($sformatf("%0d expected beats never came out", beat_q.size()));
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* xgmii_axis_rx.f */
rtl/xgmii_rx_pkg.sv
rtl/xgmii_word_if.sv
rtl/xgmii_rx_decode.sv
rtl/xgmii_rx_framer.sv
rtl/xgmii_axis_rx.sv
dv/tb_clock_gen.sv
dv/xgmii_axis_rx_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert --top-module xgmii_axis_rx_tb -f xgmii_axis_rx.f \
    && ./obj_dir/Vxgmii_axis_rx_tb | tee /dev/stderr | grep -q "Verification passed" \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }
